//--- hw/touch_macros.svh
// Touch reader constants
`ifndef TOUCH_MACROS_SVH
`define TOUCH_MACROS_SVH

// Touch controller on the I2C bus
`define TOUCH_SLAVE_ADDR 7'h38

// First coordinate register, XH
`define TOUCH_REG_FIRST 8'h03

// XH, XL, YH, YL read per touch
`define TOUCH_REG_COUNT 4

// Data bits per I2C byte, ACK bit not counted
`define I2C_BYTE_BITS 8

// System clocks per SCL half period
// At least 2, so SDA can move one clock after SCL falls
`define SCL_HALF_CYCLES 2

`endif

//--- hw/i2c_pkg.sv
// I2C bus types
package i2c_pkg;

`include "touch_macros.svh"

    // One byte as it travels on SDA, MSB first
    typedef logic [`I2C_BYTE_BITS-1:0] i2c_byte_t;

    // Operations the byte engine performs
    typedef enum logic [1:0] {
        I2C_START = 2'd0, // SDA falls while SCL high
        I2C_STOP  = 2'd1, // SDA rises while SCL high, bus left idle
        I2C_WRITE = 2'd2, // 8 bits out, ACK sampled from slave
        I2C_READ  = 2'd3  // 8 bits in, master ACK driven
    } i2c_cmd_t;

endpackage

//--- hw/touch_pkg.sv
// Touch coordinate types
package touch_pkg;

`include "touch_macros.svh"

    // Coordinate bytes, MSB first, so XH lands in bits 7:0
    typedef struct packed {
        logic [`I2C_BYTE_BITS-1:0] yl; // Bits 31:24
        logic [`I2C_BYTE_BITS-1:0] yh;
        logic [`I2C_BYTE_BITS-1:0] xl;
        logic [`I2C_BYTE_BITS-1:0] xh; // Bits 7:0
    } coord_bytes_t;

    // Same 32 bits seen as one word or as four named bytes
    typedef union packed {
        logic [4*`I2C_BYTE_BITS-1:0] word; // Raw view for data_out
        coord_bytes_t                bytes; // Filled one read at a time
    } coord_word_u;

    // Register being read, offset from TOUCH_REG_FIRST
    typedef logic [$clog2(`TOUCH_REG_COUNT)-1:0] touch_reg_idx_t;

endpackage

//--- hw/i2c_byte_if.sv
// Sequencer to byte engine link
`timescale 1ns/10ps

interface i2c_byte_if import i2c_pkg::*; ();

    // Request side, held stable until ready
    logic      valid;   // Command waiting
    i2c_cmd_t  cmd;     // What to do on the bus
    i2c_byte_t tx_byte; // Byte for I2C_WRITE
    logic      rd_ack;  // Master ACKs after I2C_READ when high

    // Engine side
    logic      ready;    // Engine idle, command taken when valid too
    logic      complete; // One cycle pulse at the end of a command
    i2c_byte_t rx_byte;  // Read data, valid with complete
    logic      ack_ok;   // Slave pulled SDA low on the ACK bit

    modport seq (
        output valid, cmd, tx_byte, rd_ack,
        input  ready, complete, rx_byte, ack_ok
    );

    modport engine (
        input  valid, cmd, tx_byte, rd_ack,
        output ready, complete, rx_byte, ack_ok
    );

endinterface

//--- hw/i2c_byte_engine.sv
// I2C byte engine
`timescale 1ns/10ps
`include "touch_macros.svh"

module i2c_byte_engine import i2c_pkg::*; (
    input  logic       clk,
    input  logic       nRst,
    i2c_byte_if.engine bus,
    input  logic       sda_in,  // Resolved SDA line
    output logic       sda_out,
    output logic       sda_oeb, // 1 = released
    output logic       scl
);

    localparam int HALF = `SCL_HALF_CYCLES;
    localparam int BITS = `I2C_BYTE_BITS;
    localparam int PH_W = $clog2(HALF);
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(HALF - 1);
    localparam logic [3:0] ACK_BIT = 4'(BITS); // Ninth slot of a byte

    logic            busy;       // Command running
    i2c_cmd_t        cmd_q;
    logic            rd_ack_q;
    i2c_byte_t       shift_q;    // Outgoing or incoming byte
    logic [PH_W-1:0] phase_cnt;  // Clock within half period
    logic            high_half;  // Second half of the bit period
    logic [3:0]      bit_cnt;    // 0..8, ACK slot last
    logic            complete_q;
    logic            ack_ok_q;

    logic is_byte;   // WRITE or READ
    logic last_bit;  // Final period of the command
    logic half_end;  // Last clock of a half period
    logic setup_pt;  // First clock of the low half, SDA may move after it
    logic ack_wait;  // Slave has not pulled SDA low yet

    assign is_byte  = (cmd_q == I2C_WRITE) || (cmd_q == I2C_READ);
    assign last_bit = is_byte ? (bit_cnt == ACK_BIT) : 1'b1; // START/STOP are one period
    assign half_end = (phase_cnt == PH_LAST);
    assign setup_pt = !high_half && (phase_cnt == '0);
    assign ack_wait = (cmd_q == I2C_WRITE) && (bit_cnt == ACK_BIT) && sda_in;

    assign bus.ready    = !busy;
    assign bus.complete = complete_q;
    assign bus.rx_byte  = shift_q;  // Holds the read byte once the shifts are done
    assign bus.ack_ok   = ack_ok_q;

    // Bit timing and line control
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy       <= 1'b0;
            cmd_q      <= I2C_START;
            rd_ack_q   <= 1'b0;
            phase_cnt  <= '0;
            high_half  <= 1'b0;
            bit_cnt    <= '0;
            complete_q <= 1'b0;
            ack_ok_q   <= 1'b0;
            scl        <= 1'b1; // Idle bus
            sda_out    <= 1'b1;
            sda_oeb    <= 1'b1;
        end else begin
            complete_q <= 1'b0;
            if (!busy) begin
                if (bus.valid) begin // Accept, SCL left where it is
                    busy      <= 1'b1;
                    cmd_q     <= bus.cmd;
                    rd_ack_q  <= bus.rd_ack;
                    phase_cnt <= '0;
                    high_half <= 1'b0;
                    bit_cnt   <= '0;
                end
            end else begin
                phase_cnt <= half_end ? '0 : phase_cnt + 1'b1;

                // SDA moves one clock into the low half
                if (setup_pt) begin
                    case (cmd_q)
                        I2C_START: begin
                            sda_oeb <= 1'b0; // High first, falls mid period
                            sda_out <= 1'b1;
                        end
                        I2C_STOP: begin
                            sda_oeb <= 1'b0; // Low so it can rise with SCL high
                            sda_out <= 1'b0;
                        end
                        I2C_WRITE: begin
                            if (bit_cnt == ACK_BIT) begin
                                sda_oeb <= 1'b1; // Slave owns the ACK slot
                                sda_out <= 1'b1;
                            end else begin
                                sda_oeb <= 1'b0;
                                sda_out <= shift_q[BITS-1]; // MSB first
                            end
                        end
                        default: begin // I2C_READ
                            if (bit_cnt == ACK_BIT) begin
                                sda_oeb <= !rd_ack_q; // Master ACK is a driven low
                                sda_out <= !rd_ack_q;
                            end else begin
                                sda_oeb <= 1'b1; // Slave drives data
                                sda_out <= 1'b1;
                            end
                        end
                    endcase
                end

                // End of low half
                if (half_end && !high_half) begin
                    high_half <= 1'b1;
                    if (cmd_q == I2C_START) begin
                        sda_out <= 1'b0; // START condition, SCL still high
                    end else begin
                        scl <= 1'b1;
                    end
                end

                // End of high half, SDA sampled here
                if (half_end && high_half) begin
                    high_half <= 1'b0;
                    if (ack_wait) begin
                        // No ACK yet, SCL stays high and the slot repeats
                    end else if (last_bit) begin
                        busy       <= 1'b0;
                        complete_q <= 1'b1;
                        ack_ok_q   <= (cmd_q == I2C_WRITE) && !sda_in;
                        if (cmd_q == I2C_STOP) begin
                            sda_oeb <= 1'b1; // STOP condition, SCL stays high
                            sda_out <= 1'b1;
                        end else begin
                            scl <= 1'b0; // Held low until the next command
                        end
                    end else begin
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Shift register
    always_ff @(posedge clk) begin
        if (!busy && bus.valid) begin
            shift_q <= bus.tx_byte;
        end else if (busy && half_end && high_half && is_byte && !last_bit) begin
            // Read shifts in SDA, write just moves the next bit up
            shift_q <= {shift_q[BITS-2:0], (cmd_q == I2C_READ) ? sda_in : 1'b0};
        end
    end

endmodule

//--- hw/touch_read_sequencer.sv
// Touch coordinate read sequencer
`timescale 1ns/10ps
`include "touch_macros.svh"

module touch_read_sequencer import touch_pkg::*, i2c_pkg::*; (
    input  logic        clk,
    input  logic        nRst,
    i2c_byte_if.seq     bus,
    input  logic        touch_int_n, // Active low, falling edge starts a read
    output logic [31:0] data_out,
    output logic        done
);

    localparam touch_reg_idx_t IDX_LAST = touch_reg_idx_t'(`TOUCH_REG_COUNT - 1);
    localparam logic [2:0] STEP_READ = 3'd6;
    localparam logic [2:0] STEP_LAST = 3'd7; // Closing STOP

    typedef enum logic [1:0] {
        S_IDLE,  // Waiting for touch
        S_ISSUE, // Offering a command
        S_WAIT   // Command on the bus
    } seq_state_t;

    seq_state_t     state;
    logic [2:0]     step_q;  // Position in the write-then-read sequence
    touch_reg_idx_t idx_q;   // Register offset
    coord_word_u    word_q;  // Bytes gathered so far
    logic           int_q;
    logic           int_prev;
    logic           int_fall;

    i2c_cmd_t  cmd_sel;
    i2c_byte_t tx_sel;
    logic      step_ok;

    assign int_fall = int_prev && !int_q; // Level held low gives one pulse only

    // Command for each step, 12 protocol steps in 8 engine commands
    always_comb begin
        cmd_sel = I2C_START;
        tx_sel  = '0;
        case (step_q)
            3'd0, 3'd4: cmd_sel = I2C_START;
            3'd1: begin
                cmd_sel = I2C_WRITE;
                tx_sel  = {`TOUCH_SLAVE_ADDR, 1'b0}; // Address + W
            end
            3'd2: begin
                cmd_sel = I2C_WRITE;
                tx_sel  = `TOUCH_REG_FIRST + i2c_byte_t'(idx_q); // Register pointer
            end
            3'd5: begin
                cmd_sel = I2C_WRITE;
                tx_sel  = {`TOUCH_SLAVE_ADDR, 1'b1}; // Address + R
            end
            3'd6: cmd_sel = I2C_READ;
            default: cmd_sel = I2C_STOP; // Steps 3 and 7
        endcase
    end

    // Writes move on only when acknowledged
    assign step_ok = (cmd_sel != I2C_WRITE) || bus.ack_ok;

    assign bus.valid   = (state == S_ISSUE);
    assign bus.cmd     = cmd_sel;
    assign bus.tx_byte = tx_sel;
    assign bus.rd_ack  = 1'b1; // Every byte gets a master ACK

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= S_IDLE;
            step_q   <= '0;
            idx_q    <= '0;
            int_q    <= 1'b1;
            int_prev <= 1'b1;
            done     <= 1'b0;
            data_out <= '0;
        end else begin
            int_q    <= touch_int_n;
            int_prev <= int_q;
            case (state)
                S_IDLE: begin
                    if (int_fall) begin // Edges during a read are ignored
                        state  <= S_ISSUE;
                        step_q <= '0;
                        idx_q  <= '0;
                        done   <= 1'b0;
                    end
                end
                S_ISSUE: begin
                    if (bus.ready) state <= S_WAIT; // Taken this cycle
                end
                default: begin // S_WAIT
                    if (bus.complete && step_ok) begin
                        if (step_q != STEP_LAST) begin
                            step_q <= step_q + 1'b1;
                            state  <= S_ISSUE;
                        end else if (idx_q != IDX_LAST) begin
                            idx_q  <= idx_q + 1'b1; // Next register
                            step_q <= '0;
                            state  <= S_ISSUE;
                        end else begin
                            data_out <= word_q.word; // Whole word at once
                            done     <= 1'b1;
                            state    <= S_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Byte placement, XH lowest
    always_ff @(posedge clk) begin
        if (state == S_WAIT && bus.complete && step_q == STEP_READ) begin
            case (idx_q)
                2'd0:    word_q.bytes.xh <= bus.rx_byte;
                2'd1:    word_q.bytes.xl <= bus.rx_byte;
                2'd2:    word_q.bytes.yh <= bus.rx_byte;
                default: word_q.bytes.yl <= bus.rx_byte;
            endcase
        end
    end

endmodule

//--- hw/touch_i2c_top.sv
// Touch I2C reader top
`timescale 1ns/10ps

module touch_i2c_top (
    input  logic        clk,
    input  logic        nRst,
    input  logic        sda_in,      // Resolved SDA line
    input  logic        touch_int_n, // Touch interrupt, active low
    output logic        sda_out,
    output logic        sda_oeb,     // 1 = SDA released
    output logic        scl,
    output logic [31:0] data_out,    // {YL, YH, XL, XH}
    output logic        done         // High while data_out holds a full touch
);

    // Command and result path between the two blocks
    i2c_byte_if byte_bus ();

    // Owns SCL and SDA
    i2c_byte_engine u_engine (
        .clk     (clk),
        .nRst    (nRst),
        .bus     (byte_bus.engine),
        .sda_in  (sda_in),
        .sda_out (sda_out),
        .sda_oeb (sda_oeb),
        .scl     (scl)
    );

    // Interrupt to coordinate word
    touch_read_sequencer u_seq (
        .clk         (clk),
        .nRst        (nRst),
        .bus         (byte_bus.seq),
        .touch_int_n (touch_int_n),
        .data_out    (data_out),
        .done        (done)
    );

endmodule

//--- verif/touch_slave_model.sv
// Touch controller I2C model
`timescale 1ns/10ps

module touch_slave_model (
    input  logic            clk,
    input  logic            scl,
    input  logic            sda_out,
    input  logic            sda_oeb,    // 1 = master released SDA
    input  logic [3:0][7:0] reg_file,   // Registers 0x03..0x06
    output logic            sda_in,     // Resolved open-drain line
    output int              xfer_count, // Completed register reads
    output logic            fault
);

    logic       pull = 1'b0;   // Slave pulls SDA low
    logic       sda;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic       in_xfer = 1'b0;
    logic       rd_mode = 1'b0;      // Current transfer is address+R
    logic       expect_read = 1'b0;  // Next transfer must be the read half
    logic [7:0] shift = '0;
    logic [7:0] tx_byte = '0;
    logic [7:0] reg_ptr = '0;
    int         bit_cnt = 0;
    int         byte_no = 0;
    int         reg_count = 0;       // Register pointers seen so far

    assign sda    = (sda_oeb | sda_out) & !pull; // Wired AND with pull-up
    assign sda_in = sda;

    initial begin
        xfer_count = 0;
        fault      = 1'b0;
    end

    task automatic protocol_error(input string what);
        $display("Touch model: %s at %0t ns", what, $time);
        fault = 1'b1;
    endtask

    // Address and register bytes from the master
    task automatic take_byte(input logic [7:0] b);
        if (byte_no == 0) begin
            if (b[7:1] != 7'h38) protocol_error("wrong slave address");
            if (b[0] != expect_read) protocol_error("wrong transfer direction");
            rd_mode = b[0];
        end else if (byte_no == 1) begin
            if (b != 8'(3 + (reg_count % 4))) protocol_error("register out of order");
            reg_ptr   = b;
            reg_count = reg_count + 1;
        end else begin
            protocol_error("extra byte in write transfer");
        end
    endtask

    // Bus sampled mid clock, away from DUT updates
    always @(negedge clk) begin
        if (!in_xfer && scl === 1'b0) protocol_error("SCL low while the bus is idle");
        if (scl_q && scl && sda_q && !sda) begin // START
            in_xfer = 1'b1;
            rd_mode = 1'b0;
            bit_cnt = 0;
            byte_no = 0;
            pull    = 1'b0;
        end else if (scl_q && scl && !sda_q && sda) begin // STOP
            if (!in_xfer || byte_no != 2) protocol_error("STOP in the middle of a transfer");
            else if (rd_mode) xfer_count = xfer_count + 1;
            expect_read = !rd_mode;
            in_xfer     = 1'b0;
            pull        = 1'b0;
        end else if (!scl_q && scl && in_xfer) begin // Rising SCL
            if (bit_cnt < 8) begin
                if (rd_mode && byte_no == 1) begin
                    if (!sda_oeb) protocol_error("master drives SDA during a data bit");
                end else begin
                    shift = {shift[6:0], sda};
                end
            end else if (rd_mode && byte_no == 1) begin
                if (sda !== 1'b0) protocol_error("data byte not acknowledged by master");
            end else if (!sda_oeb) begin
                protocol_error("master drives SDA in the ACK slot");
            end
            bit_cnt = bit_cnt + 1;
        end else if (scl_q && !scl && in_xfer) begin // Falling SCL
            if (bit_cnt == 8) begin
                pull = !(rd_mode && byte_no == 1); // ACK, or release after data
                if (pull) take_byte(shift);
            end else if (bit_cnt == 9) begin
                pull    = 1'b0;
                bit_cnt = 0;
                byte_no = byte_no + 1;
                if (rd_mode && byte_no == 1) begin
                    tx_byte = reg_file[int'(reg_ptr) - 3];
                    pull    = !tx_byte[7]; // MSB first
                end
            end else if (rd_mode && byte_no == 1) begin
                pull = !tx_byte[7 - bit_cnt];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- verif/touch_i2c_tb.sv
// Touch I2C reader testbench
`timescale 1ns/10ps

module touch_i2c_tb;

    logic            clk;
    logic            nRst;
    logic            touch_int_n;
    logic            sda_in;
    logic            sda_out;
    logic            sda_oeb;
    logic            scl;
    logic            done;
    logic [31:0]     data_out;
    logic [3:0][7:0] reg_file;  // Model registers, index 0 is XH
    int              xfer_count;
    logic            fault;
    logic            loaded;

    logic [7:0]  stim_xh[$];
    logic [7:0]  stim_xl[$];
    logic [7:0]  stim_yh[$];
    logic [7:0]  stim_yl[$];
    logic [31:0] stim_word[$];  // Expected word from the file

    always #4 clk = ~clk; // 8 ns period

    touch_i2c_top uut (
        .clk         (clk),
        .nRst        (nRst),
        .sda_in      (sda_in),
        .touch_int_n (touch_int_n),
        .sda_out     (sda_out),
        .sda_oeb     (sda_oeb),
        .scl         (scl),
        .data_out    (data_out),
        .done        (done)
    );

    touch_slave_model model (
        .clk        (clk),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oeb    (sda_oeb),
        .reg_file   (reg_file),
        .sda_in     (sda_in),
        .xfer_count (xfer_count),
        .fault      (fault)
    );

    task automatic report_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    // One touch per line, comment lines skipped
    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  b0, b1, b2, b3;
        logic [31:0] w;
        fd = $fopen("verif/touch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            report_failure();
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h", b0, b1, b2, b3, w);
            if (line.substr(0, 0) != "#" && n == 5) begin
                stim_xh.push_back(b0);
                stim_xl.push_back(b1);
                stim_yh.push_back(b2);
                stim_yl.push_back(b3);
                stim_word.push_back(w);
            end
        end
        $fclose(fd);
    endtask

    always @(posedge fault) report_failure();

    // Watchdog, 20 us per touch plus margin
    initial begin
        wait (loaded);
        #(stim_word.size() * 20000 + 2000);
        $display("Timeout: the touch reads did not finish in time");
        report_failure();
    end

    initial begin
        int          gap;
        int          low_cycles;
        logic [31:0] exp_word;
        clk         = 1'b0;
        nRst        = 1'b0;
        touch_int_n = 1'b1;
        reg_file    = '0;
        loaded      = 1'b0;
        void'($urandom(32'h02713066));
        load_stimulus();
        if (stim_word.size() == 0) begin
            $display("The stimulus file holds no touches");
            report_failure();
        end
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("reset scl", 1, scl);
        check("reset sda_out", 1, sda_out);
        check("reset sda_oeb", 1, sda_oeb);
        check("reset done", 0, done);
        check("reset data_out", 0, data_out);
        nRst = 1'b1;
        repeat (3) @(negedge clk);
        for (int i = 0; i < stim_word.size(); i++) begin
            reg_file = {stim_yl[i], stim_yh[i], stim_xl[i], stim_xh[i]};
            exp_word = {stim_yl[i], stim_yh[i], stim_xl[i], stim_xh[i]}; // XH lowest
            check("stimulus word", stim_word[i], exp_word);
            low_cycles  = 2 + ($urandom % 4);
            touch_int_n = 1'b0;
            repeat (2) @(negedge clk); // Edge registered, done cleared
            check("done cleared", 0, done);
            repeat (low_cycles - 2) @(negedge clk);
            if (i % 2 == 0) begin
                touch_int_n = 1'b1;
                repeat (10 + ($urandom % 30)) @(negedge clk);
                touch_int_n = 1'b0; // Second edge inside the read
                repeat (2) @(negedge clk);
                touch_int_n = 1'b1;
            end
            while (!done) @(negedge clk); // Odd lines keep the level low
            check("data_out", exp_word, data_out);
            check("transaction count", 4 * (i + 1), xfer_count);
            gap = 20 + ($urandom % 40);
            repeat (gap) begin
                @(negedge clk);
                check("data_out hold", exp_word, data_out);
                check("done hold", 1, done);
            end
            touch_int_n = 1'b1;
            repeat (3) @(negedge clk);
        end
        // Idle long enough for a stray register read to reach its STOP
        repeat (400) begin
            @(negedge clk);
            check("done after last touch", 1, done);
        end
        check("final transaction count", 4 * stim_word.size(), xfer_count);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- verif/touch_stimulus.txt
# One touch per line: XH XL YH YL registers, then the expected data_out word
# Word layout is {YL, YH, XL, XH}
01 2c 00 f0 f0002c01
02 58 01 e0 e0015802
00 00 00 00 00000000
0f ff 0f ff ff0fff0f
80 01 7f fe fe7f0180
03 20 01 90 90012003
a5 5a c3 3c 3cc35aa5
00 10 02 00 00021000
04 00 02 58 58020004
ff 00 ff 00 00ff00ff

//--- build.f
+incdir+hw
hw/i2c_pkg.sv
hw/touch_pkg.sv
hw/i2c_byte_if.sv
hw/i2c_byte_engine.sv
hw/touch_read_sequencer.sv
hw/touch_i2c_top.sv
verif/touch_slave_model.sv
verif/touch_i2c_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build with Verilator and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f build.f --top-module touch_i2c_tb &&
./obj_dir/Vtouch_i2c_tb | grep "TESTBENCH PASSED" &&
echo "Simulation finished without errors" ||
{ echo "Simulation did not pass"; exit 1; }
